// ==== list.f ====
+incdir+dv
hw/scene_pkg.sv
hw/pixel_pkg.sv
hw/ray_if.sv
hw/ray_issue.sv
hw/ray_stage.sv
hw/shade_store.sv
hw/raymarcher.sv
dv/raymarcher_tb.sv

// ==== dv/ref_model.svh ====
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

// galois form with taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
endfunction

// march one ray a step at a time until it hits or passes the maximum depth
function automatic void march_ref(input longint ex, input longint ey, input longint ez,
                                  input int x, input int y, output logic hit,
                                  output longint depth, output int steps);
    longint pt [3];
    longint dir [3];
    longint sdf;
    longint mag;
    logic   done;
    pt[0]  = ex;
    pt[1]  = ey;
    pt[2]  = ez;
    dir[0] = x - SCREEN_W / 2;
    dir[1] = y - SCREEN_H / 2;
    dir[2] = -FOCAL;
    hit    = 1'b0;
    done   = 1'b0;
    depth  = 0;
    steps  = 0;
    while (!done) begin
        sdf = 0;
        for (int i = 0; i < 3; i++) begin
            mag = (pt[i] < 0) ? -pt[i] : pt[i];
            if (mag > sdf)
                sdf = mag;
        end
        sdf = sdf - CUBE_HALF;
        steps++;
        if (sdf < EPSILON) begin
            hit  = 1'b1;
            done = 1'b1;
        end else begin
            for (int i = 0; i < 3; i++)
                pt[i] = pt[i] + ((dir[i] * sdf) >>> DIR_SHIFT);
            depth = depth + sdf;
            done  = (depth >= MAX_DEPTH);
        end
    end
endfunction

// hits take red from integer depth plus the offset and full blue while misses stay black
function automatic color_t shade_ref(input logic hit, input longint depth);
    color_t c;
    int     red8;
    c = '0;
    if (hit) begin
        red8        = int'(((depth >>> FRAC_BITS) + COLOR_HIT_OFFSET) & 255);
        c.rgb.red   = 5'(red8 >> 3);
        c.rgb.green = '0;
        c.rgb.blue  = 5'(255 >> 3);
    end
    return c;
endfunction

// one trip covers NUM_STAGES steps
function automatic int trips_ref(input int steps);
    return (steps + NUM_STAGES - 1) / NUM_STAGES;
endfunction

`endif

// ==== dv/raymarcher_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module raymarcher_tb;
    import scene_pkg::*;
    import pixel_pkg::*;

    `include "ref_model.svh"

    localparam int RD_BURST = 512;

    logic        clk;
    logic        reset;
    fix_t        eye_x, eye_y, eye_z;
    coord_t      rd_x, rd_y;
    logic [15:0] rd_color;

    color_t      exp_frame [FB_DEPTH];
    color_t      exp_q [$];
    addr_t       addr_q [$];
    logic [31:0] lfsr;
    int          eye_tab [4][3];
    int          bound [4];
    int          cycles = 0;
    int          limit = 2_000_000_000;
    int          cmp_done, cmp_bad, count_bad;
    int          tests_run, tests_failed, bad_total;

    raymarcher dut (
        .clk        (clk),
        .reset      (reset),
        .i_eye_x    (eye_x),
        .i_eye_y    (eye_y),
        .i_eye_z    (eye_z),
        .i_rd_x     (rd_x),
        .i_rd_y     (rd_y),
        .o_rd_color (rd_color)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // one lfsr step per bit taken
    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v    = (v << 1) | lfsr[0];
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    // expected frame and the settle bound for one eye position
    function automatic void build_frame(input int ex, input int ey, input int ez,
                                        output int wait_cycles);
        logic   hit;
        longint depth;
        int     steps, trips, sum_trips, max_trips;
        sum_trips = 0;
        max_trips = 0;
        for (int y = 0; y < SCREEN_H; y++) begin
            for (int x = 0; x < SCREEN_W; x++) begin
                march_ref(longint'(ex) <<< FRAC_BITS, longint'(ey) <<< FRAC_BITS,
                          longint'(ez) <<< FRAC_BITS, x, y, hit, depth, steps);
                exp_frame[y * SCREEN_W + x] = shade_ref(hit, depth);
                trips = trips_ref(steps);
                sum_trips += trips;
                if (trips > max_trips)
                    max_trips = trips;
            end
        end
        wait_cycles = sum_trips * LOOP_LEN + LOOP_LEN * (max_trips + 2);
    endfunction

    task automatic check_color(input string name, input addr_t a, input color_t got,
                               input color_t exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s at addr %0d got %h expected %h",
                     $time, name, a, got.raw, exp.raw);
            cmp_bad++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("FAIL t=%0t %s got %0d expected %0d", $time, name, got, exp);
            count_bad++;
        end
    endtask

    // compares each read one cycle after its address was applied
    always begin
        @(posedge clk);
        #1;
        if (exp_q.size() > 0) begin
            check_color("o_rd_color", addr_q.pop_front(), rd_color, exp_q.pop_front());
            cmp_done++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= limit) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic set_eye(input int x, input int y, input int z);
        @(posedge clk);
        #2;
        eye_x = fix_t'(longint'(x) <<< FRAC_BITS);
        eye_y = fix_t'(longint'(y) <<< FRAC_BITS);
        eye_z = fix_t'(longint'(z) <<< FRAC_BITS);
    endtask

    task automatic apply_read(input int x, input int y);
        addr_t a;
        a = addr_t'(y * SCREEN_W + x);
        @(posedge clk);
        #2;
        rd_x = coord_t'(x);
        rd_y = coord_t'(y);
        exp_q.push_back(exp_frame[a]);
        addr_q.push_back(a);
    endtask

    task automatic start_test();
        cmp_done  = 0;
        cmp_bad   = 0;
        count_bad = 0;
    endtask

    task automatic finish_test(input string name);
        // let the last read reach the compare process
        @(posedge clk);
        #2;
        check_count("mismatches", cmp_bad, 0);
        tests_run++;
        bad_total += cmp_bad;
        if (count_bad != 0)
            tests_failed++;
        $display("test %0d %s: %s, %0d reads, %0d mismatches", tests_run, name,
                 (count_bad == 0) ? "ok" : "FAILING", cmp_done, cmp_bad);
    endtask

    // reads back the whole settled frame and compares it with the reference or a flat colour
    task automatic frame_test(input string name, input int t, input logic flat,
                              input color_t c);
        int wait_cycles;
        start_test();
        set_eye(eye_tab[t][0], eye_tab[t][1], eye_tab[t][2]);
        build_frame(eye_tab[t][0], eye_tab[t][1], eye_tab[t][2], wait_cycles);
        if (flat) begin
            for (int i = 0; i < FB_DEPTH; i++)
                exp_frame[i] = c;
        end
        repeat (wait_cycles) @(posedge clk);
        for (int y = 0; y < SCREEN_H; y++) begin
            for (int x = 0; x < SCREEN_W; x++)
                apply_read(x, y);
        end
        finish_test(name);
    endtask

    initial begin : main
        int     wait_total;
        color_t in_cube;
        reset = 1'b1;
        eye_x = '0;
        eye_y = '0;
        eye_z = '0;
        rd_x  = '0;
        rd_y  = '0;
        lfsr  = 32'h4393e9a9;
        tests_run    = 0;
        tests_failed = 0;
        bad_total    = 0;
        start_test();

        eye_tab[0] = '{0, 0, 120};
        eye_tab[1] = '{400, 0, 120};
        eye_tab[2] = '{0, 0, 0};
        for (int i = 0; i < 3; i++)
            eye_tab[3][i] = (take_bits(7) % 121) - 60;

        // run length from the settle bounds of all four frames
        wait_total = 0;
        for (int t = 0; t < 4; t++) begin
            build_frame(eye_tab[t][0], eye_tab[t][1], eye_tab[t][2], bound[t]);
            wait_total += bound[t];
        end
        limit = 3 + wait_total + 4 * (FB_DEPTH + 4) + RD_BURST + 500;

        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;

        // every ray hits on its first step at depth 0
        in_cube          = '0;
        in_cube.rgb.red  = 5'(125 >> 3);
        in_cube.rgb.blue = 5'd31;

        frame_test("eye (0,0,120) full frame", 0, 1'b0, '0);
        frame_test("eye (400,0,120) all miss", 1, 1'b1, '0);
        frame_test("eye inside cube", 2, 1'b1, in_cube);
        frame_test($sformatf("eye (%0d,%0d,%0d) random", eye_tab[3][0], eye_tab[3][1],
                             eye_tab[3][2]), 3, 1'b0, '0);

        // frame from the random eye is still in place
        start_test();
        for (int i = 0; i < RD_BURST; i++)
            apply_read(take_bits(6), take_bits(6) % SCREEN_H);
        finish_test("back to back reads");

        $display("summary: %0d tests, %0d failing, %0d mismatches in total",
                 tests_run, tests_failed, bad_total);
        if (tests_failed == 0 && tests_run == 5) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/raymarcher.sv ====
`timescale 1ns/1ns
`default_nettype none

module raymarcher (
    input  logic              clk,
    input  logic              reset,
    input  scene_pkg::fix_t   i_eye_x,
    input  scene_pkg::fix_t   i_eye_y,
    input  scene_pkg::fix_t   i_eye_z,
    input  pixel_pkg::coord_t i_rd_x,
    input  pixel_pkg::coord_t i_rd_y,
    output logic [15:0]       o_rd_color
);
    import scene_pkg::*;
    import pixel_pkg::*;

    addr_t  rd_addr;
    color_t rd_color;

    // link 0 from the issue unit, last link back to issue and store
    ray_if link [NUM_STAGES+1] ();

    assign rd_addr    = pix_addr(i_rd_x, i_rd_y);
    assign o_rd_color = rd_color.raw;

    ray_issue u_issue (
        .i_clk     (clk),
        .i_reset   (reset),
        .i_eye_x   (i_eye_x),
        .i_eye_y   (i_eye_y),
        .i_eye_z   (i_eye_z),
        .loop_in   (link[NUM_STAGES]),
        .issue_out (link[0])
    );

    generate
        for (genvar k = 0; k < NUM_STAGES; k++) begin : g_stage
            ray_stage u_stage (
                .i_clk   (clk),
                .i_reset (reset),
                .ray_in  (link[k]),
                .ray_out (link[k+1])
            );
        end
    endgenerate

    shade_store u_store (
        .i_clk      (clk),
        .loop_in    (link[NUM_STAGES]),
        .i_rd_addr  (rd_addr),
        .o_rd_color (rd_color)
    );

endmodule

`default_nettype wire

// ==== hw/shade_store.sv ====
`timescale 1ns/1ns
`default_nettype none

module shade_store (
    input  logic              i_clk,
    ray_if.dst                loop_in,
    input  pixel_pkg::addr_t  i_rd_addr,
    output pixel_pkg::color_t o_rd_color
);
    import scene_pkg::*;
    import pixel_pkg::*;

    logic [7:0] red8;
    logic       wr_en;
    addr_t      wr_addr;
    color_t     wr_color;
    color_t     fb_mem [FB_DEPTH];

    assign wr_en   = loop_in.valid & loop_in.done;
    assign wr_addr = pix_addr(loop_in.px, loop_in.py);

    // integer part of depth, wraps modulo 256
    assign red8 = loop_in.depth[FRAC_BITS +: 8] + COLOR_HIT_OFFSET;

    // misses stay black
    always_comb begin
        wr_color = '0;
        if (loop_in.hit) begin
            wr_color.rgb.red   = red8[7:3];
            wr_color.rgb.green = '0;
            wr_color.rgb.blue  = BLUE_HIT[7:3];
        end
    end

    // write port from the loop end, registered read port
    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            fb_mem[wr_addr] <= wr_color;
        end
        o_rd_color <= fb_mem[i_rd_addr];
    end

    a_wr_in_frame: assert property (
        @(posedge i_clk) wr_en |-> (wr_addr < FB_DEPTH)
    ) else $error("frame buffer write outside screen at %0d", wr_addr);

endmodule

`default_nettype wire

// ==== hw/ray_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module ray_stage (
    input logic i_clk,
    input logic i_reset,
    ray_if.dst  ray_in,
    ray_if.src  ray_out
);
    import scene_pkg::*;
    import pixel_pkg::*;

    fix_t   pt_in [3];
    fix_t   dir_in [3];
    fix_t   cheb;
    // cycle 1
    logic   v1, done1, hit1;
    coord_t px1, py1;
    fix_t   pt1 [3];
    fix_t   dir1 [3];
    fix_t   depth1, dist1;
    // cycle 2
    logic   v2, done2, hit2, near2;
    coord_t px2, py2;
    fix_t   pt2 [3];
    fix_t   dir2 [3];
    fix_t   step2 [3];
    fix_t   depth2, dist2;
    logic signed [2*FIX_W-1:0] prod [3];
    fix_t   next_depth;

    function automatic fix_t abs_fix(fix_t a);
        return a[FIX_W-1] ? -a : a;
    endfunction

    assign pt_in[0]  = ray_in.pt_x;
    assign pt_in[1]  = ray_in.pt_y;
    assign pt_in[2]  = ray_in.pt_z;
    assign dir_in[0] = ray_in.dir_x;
    assign dir_in[1] = ray_in.dir_y;
    assign dir_in[2] = ray_in.dir_z;

    // largest absolute coordinate
    always_comb begin
        cheb = abs_fix(pt_in[0]);
        if (abs_fix(pt_in[1]) > cheb)
            cheb = abs_fix(pt_in[1]);
        if (abs_fix(pt_in[2]) > cheb)
            cheb = abs_fix(pt_in[2]);
    end

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            prod[i] = dir1[i] * dist1;
        end
    end

    assign next_depth = depth2 + dist2;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            v1            <= 1'b0;
            v2            <= 1'b0;
            ray_out.valid <= 1'b0;
        end else begin
            v1            <= ray_in.valid;
            v2            <= v1;
            ray_out.valid <= v2;
        end
    end

    // distance to the cube surface
    always_ff @(posedge i_clk) begin
        done1  <= ray_in.done;
        hit1   <= ray_in.hit;
        px1    <= ray_in.px;
        py1    <= ray_in.py;
        pt1    <= pt_in;
        dir1   <= dir_in;
        depth1 <= ray_in.depth;
        dist1  <= cheb - CUBE_HALF;
    end

    // scaled direction and hit test
    always_ff @(posedge i_clk) begin
        done2  <= done1;
        hit2   <= hit1;
        px2    <= px1;
        py2    <= py1;
        pt2    <= pt1;
        dir2   <= dir1;
        depth2 <= depth1;
        dist2  <= dist1;
        near2  <= dist1 < EPSILON;
        for (int i = 0; i < 3; i++) begin
            step2[i] <= fix_t'(prod[i] >>> DIR_SHIFT);
        end
    end

    // point and depth update, default is pass through
    always_ff @(posedge i_clk) begin
        ray_out.px    <= px2;
        ray_out.py    <= py2;
        ray_out.dir_x <= dir2[0];
        ray_out.dir_y <= dir2[1];
        ray_out.dir_z <= dir2[2];
        ray_out.done  <= done2;
        ray_out.hit   <= hit2;
        ray_out.pt_x  <= pt2[0];
        ray_out.pt_y  <= pt2[1];
        ray_out.pt_z  <= pt2[2];
        ray_out.depth <= depth2;
        if (v2 && !done2) begin
            if (near2) begin
                ray_out.done <= 1'b1;
                ray_out.hit  <= 1'b1;
            end else begin
                ray_out.pt_x  <= pt2[0] + step2[0];
                ray_out.pt_y  <= pt2[1] + step2[1];
                ray_out.pt_z  <= pt2[2] + step2[2];
                ray_out.depth <= next_depth;
                ray_out.done  <= next_depth >= MAX_DEPTH;
            end
        end
    end

    // a retired ray is frozen through the stage
    a_done_frozen: assert property (
        @(posedge i_clk) disable iff (i_reset)
        (ray_in.valid && ray_in.done) |-> ##STAGE_LATENCY
            (ray_out.pt_x == $past(ray_in.pt_x, STAGE_LATENCY)) &&
            (ray_out.pt_y == $past(ray_in.pt_y, STAGE_LATENCY)) &&
            (ray_out.pt_z == $past(ray_in.pt_z, STAGE_LATENCY)) &&
            (ray_out.depth == $past(ray_in.depth, STAGE_LATENCY))
    ) else $error("retired ray changed inside stage");

endmodule

`default_nettype wire

// ==== hw/ray_issue.sv ====
`timescale 1ns/1ns
`default_nettype none

module ray_issue (
    input  logic            i_clk,
    input  logic            i_reset,
    input  scene_pkg::fix_t i_eye_x,
    input  scene_pkg::fix_t i_eye_y,
    input  scene_pkg::fix_t i_eye_z,
    ray_if.dst              loop_in,
    ray_if.src              issue_out
);
    import scene_pkg::*;
    import pixel_pkg::*;

    coord_t x_cnt;
    coord_t y_cnt;
    logic   new_pixel;

    // a free slot is one that is empty or has just retired
    assign new_pixel = !loop_in.valid || loop_in.done;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            issue_out.valid <= 1'b0;
            x_cnt           <= '0;
            y_cnt           <= '0;
        end else begin
            // every slot leaving issue holds either a new or a recirculated ray
            issue_out.valid <= 1'b1;
            if (new_pixel) begin
                // advance in raster order and wrap at the end of the frame
                if (x_cnt == coord_t'(SCREEN_W - 1)) begin
                    x_cnt <= '0;
                    y_cnt <= (y_cnt == coord_t'(SCREEN_H - 1)) ? '0 : y_cnt + 1'b1;
                end else begin
                    x_cnt <= x_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (new_pixel) begin
            issue_out.done  <= 1'b0;
            issue_out.hit   <= 1'b0;
            issue_out.px    <= x_cnt;
            issue_out.py    <= y_cnt;
            issue_out.pt_x  <= i_eye_x;
            issue_out.pt_y  <= i_eye_y;
            issue_out.pt_z  <= i_eye_z;
            // screen-centred direction as whole numbers
            issue_out.dir_x <= fix_t'(x_cnt) - fix_t'(SCREEN_W / 2);
            issue_out.dir_y <= fix_t'(y_cnt) - fix_t'(SCREEN_H / 2);
            issue_out.dir_z <= -fix_t'(FOCAL);
            issue_out.depth <= '0;
        end else begin
            issue_out.done  <= loop_in.done;
            issue_out.hit   <= loop_in.hit;
            issue_out.px    <= loop_in.px;
            issue_out.py    <= loop_in.py;
            issue_out.pt_x  <= loop_in.pt_x;
            issue_out.pt_y  <= loop_in.pt_y;
            issue_out.pt_z  <= loop_in.pt_z;
            issue_out.dir_x <= loop_in.dir_x;
            issue_out.dir_y <= loop_in.dir_y;
            issue_out.dir_z <= loop_in.dir_z;
            issue_out.depth <= loop_in.depth;
        end
    end

    a_raster_on_screen: assert property (
        @(posedge i_clk) disable iff (i_reset)
        y_cnt < SCREEN_H
    ) else $error("raster counter off screen at (%0d,%0d)", x_cnt, y_cnt);

endmodule

`default_nettype wire

// ==== hw/ray_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// one slot of ray state, presented every cycle
interface ray_if;
    import scene_pkg::*;
    import pixel_pkg::*;

    logic   valid;
    // retired, and retired on a hit
    logic   done;
    logic   hit;
    coord_t px;
    coord_t py;
    fix_t   pt_x;
    fix_t   pt_y;
    fix_t   pt_z;
    fix_t   dir_x;
    fix_t   dir_y;
    fix_t   dir_z;
    fix_t   depth;

    modport src (
        output valid, done, hit, px, py,
        output pt_x, pt_y, pt_z, dir_x, dir_y, dir_z, depth
    );

    modport dst (
        input valid, done, hit, px, py,
        input pt_x, pt_y, pt_z, dir_x, dir_y, dir_z, depth
    );

endinterface

`default_nettype wire

// ==== hw/pixel_pkg.sv ====
`default_nettype none

package pixel_pkg;

    localparam int SCREEN_W = 64;
    localparam int SCREEN_H = 48;
    localparam int FB_DEPTH = SCREEN_W * SCREEN_H;

    localparam int COORD_W = 6;
    localparam int ADDR_W  = 12;

    typedef logic [COORD_W-1:0] coord_t;
    typedef logic [ADDR_W-1:0]  addr_t;

    // shading constants for a hit
    localparam logic [7:0] COLOR_HIT_OFFSET = 8'd125;
    localparam logic [7:0] BLUE_HIT         = 8'hff;

    // RGB565 view for the shader, raw word for storage and output
    typedef union packed {
        struct packed {
            logic [4:0] red;
            logic [5:0] green;
            logic [4:0] blue;
        } rgb;
        logic [15:0] raw;
    } color_t;

    // row major frame-buffer address
    function automatic addr_t pix_addr(coord_t x, coord_t y);
        return addr_t'(y) * addr_t'(SCREEN_W) + addr_t'(x);
    endfunction

endpackage

`default_nettype wire

// ==== hw/scene_pkg.sv ====
`default_nettype none

package scene_pkg;

    // signed fixed point, 16 integer and 8 fraction bits
    localparam int FRAC_BITS = 8;
    localparam int FIX_W     = 24;

    typedef logic signed [FIX_W-1:0] fix_t;

    // cube centred on the origin, Chebyshev metric
    localparam fix_t CUBE_HALF = fix_t'(16 << FRAC_BITS);

    // 0.25 hit threshold and 200.0 miss threshold
    localparam fix_t EPSILON   = fix_t'(1 << (FRAC_BITS - 2));
    localparam fix_t MAX_DEPTH = fix_t'(200 << FRAC_BITS);

    // directions are plain integers, z is always -FOCAL
    // step = dir * dist >>> DIR_SHIFT, so a z step equals the distance
    localparam int FOCAL     = 64;
    localparam int DIR_SHIFT = 6;

    // loop geometry, one issue register plus the stage pipelines
    localparam int NUM_STAGES    = 4;
    localparam int STAGE_LATENCY = 3;
    localparam int LOOP_LEN      = 1 + NUM_STAGES * STAGE_LATENCY;

endpackage

`default_nettype wire
